/* Makefile */
# Verilator build and run for the CSR subsystem testbench

VERILATOR ?= verilator
TOP       ?= tbCsrSubsystem
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
FILELIST  ?= tb.f

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) verification/csrModel.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	$(SIM) | awk '{ print } /^All tests passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

/* hdl/csrDecodeStage.sv */
/*
 First pipeline stage
 Registers a CSR request or a core exception
 Illegal CSR accesses become illegal-instruction exceptions
*/
module csrDecodeStage (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            reqValid,
    input  logic [csrPkg::csrNumWidth-1:0]  reqNumber,
    input  csrPkg::csrOpE                   reqOp,
    input  logic [csrPkg::xlen-1:0]         reqWriteData,
    input  logic [csrPkg::xlen-1:0]         reqPc,
    input  logic                            excValid,
    input  trapPkg::causeE                  excCause,
    input  logic [csrPkg::xlen-1:0]         excPc,
    input  logic [csrPkg::xlen-1:0]         excTval,
    output logic                            decValid,
    output logic                            decIsExc,
    output trapPkg::causeE                  decCause,
    output logic [csrPkg::csrNumWidth-1:0]  decNumber,
    output csrPkg::csrOpE                   decOp,
    output logic [csrPkg::xlen-1:0]         decData,
    output logic [csrPkg::xlen-1:0]         decPc,
    output logic [csrPkg::xlen-1:0]         decTval
);
    import csrPkg::*;
    import trapPkg::*;

    logic knownNumber;
    logic mipModify;
    logic illegal;

    always_comb begin
        case (reqNumber)
            csrNumMstatus, csrNumMie, csrNumMip, csrNumMtvec,
            csrNumMepc, csrNumMcause, csrNumMtval, csrNumMscratch,
            csrNumMcycle, csrNumMcycleh, csrNumMinstret, csrNumMinstreth,
            csrNumAxlevel: knownNumber = 1'b1;
            default:       knownNumber = 1'b0;
        endcase
    end

    // mip is read only, a clear of nothing is just a read
    assign mipModify = (reqNumber == csrNumMip)
                       && !(reqOp == csrOpClear && reqWriteData == '0);
    assign illegal = !knownNumber || mipModify;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid <= 1'b0;
            decIsExc <= 1'b0;
        end else begin
            decValid <= reqValid || excValid;
            decIsExc <= excValid || (reqValid && illegal);   // Exception wins
        end
    end

    always_ff @(posedge clk) begin
        decCause <= excValid ? excCause : cauIllegalInsn;
        decNumber <= reqNumber;
        decOp <= reqOp;
        decData <= reqWriteData;
        decPc <= excValid ? excPc : reqPc;    // Also tracked when idle
        // tval of an illegal access is the CSR number
        decTval <= excValid ? excTval : xlen'(reqNumber);
    end

endmodule

/* hdl/csrFile.sv */
/*
 Machine-mode CSR registers with 64-bit cycle and instret counters
 Combinational read mux, write/set/clear and trap state updates
*/
module csrFile (
    input  logic                                        clk,
    input  logic                                        arstN,
    input  logic                                        takeInterrupt,
    input  logic                                        takeException,
    input  logic                                        takeCsrOp,
    input  logic [trapPkg::causeWidth-1:0]              trapCode,
    input  logic                                        trapIsInterrupt,
    input  logic [csrPkg::csrNumWidth-1:0]              decNumber,
    input  csrPkg::csrOpE                               decOp,
    input  logic [csrPkg::xlen-1:0]                     decData,
    input  logic [csrPkg::xlen-1:0]                     decPc,
    input  logic [csrPkg::xlen-1:0]                     decTval,
    input  logic [csrPkg::retireWidth-1:0]              retireCount,
    input  logic                                        irqTimer,
    input  logic                                        irqExternal,
    output logic [csrPkg::xlen-1:0]                     readData,
    output logic                                        mstatusMie,
    output logic [csrPkg::xlen-1:0]                     mieBits,
    output logic [csrPkg::xlen-1:0]                     mipBits,
    output logic [csrPkg::xlen-1:csrPkg::mtvecBaseLsb]  mtvecBase,
    output logic [csrPkg::xlen-1:0]                     mepcValue
);
    import csrPkg::*;
    import trapPkg::*;

    logic [xlen-1:0]        mstatus;
    logic [xlen-1:0]        mie;
    logic [xlen-1:0]        mepc;
    logic [xlen-1:0]        mcause;
    logic [xlen-1:0]        mtval;
    logic [xlen-1:0]        mscratch;
    logic [xlen-1:0]        axlevel;
    logic                   mipTimer;
    logic                   mipExternal;
    logic [xlen-1:0]        mcycle;
    logic [xlen-1:0]        mcycleh;
    logic [xlen-1:0]        minstret;
    logic [xlen-1:0]        minstreth;
    logic [retireWidth-1:0] retireReg;      // retireCount delayed by one cycle

    logic [xlen:0]          cycleSum;       // Top bit is the carry
    logic [xlen:0]          instretSum;
    logic [xlen-1:0]        writeValue;
    logic                   isMret;
    logic                   readOnly;       // Clear of zero

    assign cycleSum = {1'b0, mcycle} + (xlen + 1)'(1);
    assign instretSum = {1'b0, minstret} + (xlen + 1)'(retireReg);
    assign isMret = takeException && (trapCode == cauMret);
    assign readOnly = (decOp == csrOpClear) && (decData == '0);

    always_comb begin
        mipBits = '0;
        mipBits[irqTimerBit] = mipTimer;
        mipBits[irqExternalBit] = mipExternal;
    end

    always_comb begin
        case (decNumber)
            csrNumMstatus:   readData = mstatus;
            csrNumMie:       readData = mie;
            csrNumMip:       readData = mipBits;
            csrNumMtvec:     readData = {mtvecBase, {mtvecBaseLsb{1'b0}}};
            csrNumMepc:      readData = mepc;
            csrNumMcause:    readData = mcause;
            csrNumMtval:     readData = mtval;
            csrNumMscratch:  readData = mscratch;
            csrNumMcycle:    readData = mcycle;
            csrNumMcycleh:   readData = mcycleh;
            csrNumMinstret:  readData = minstret;
            csrNumMinstreth: readData = minstreth;
            csrNumAxlevel:   readData = axlevel;
            default:         readData = '0;
        endcase
    end

    // Modify against the old value
    always_comb begin
        case (decOp)
            csrOpSet:   writeValue = readData | decData;
            csrOpClear: writeValue = readData & ~decData;
            default:    writeValue = decData;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mstatus <= '0;
            mie <= '0;
            mtvecBase <= '0;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
            mscratch <= '0;
            axlevel <= '0;
            mipTimer <= 1'b0;
            mipExternal <= 1'b0;
            mcycle <= '0;
            mcycleh <= '0;
            minstret <= '0;
            minstreth <= '0;
            retireReg <= '0;
        end else begin
            mcycle <= cycleSum[xlen-1:0];
            mcycleh <= mcycleh + xlen'(cycleSum[xlen]);
            minstret <= instretSum[xlen-1:0];
            minstreth <= minstreth + xlen'(instretSum[xlen]);
            retireReg <= retireCount;
            mipTimer <= irqTimer;
            mipExternal <= irqExternal;

            if (takeInterrupt || (takeException && !isMret)) begin
                mstatus[mstatusMpieBit] <= mstatus[mstatusMieBit];
                mstatus[mstatusMieBit] <= 1'b0;     // Global enable off
                mepc <= decPc;
                mcause <= {trapIsInterrupt, {(mcauseIntBit - causeWidth){1'b0}}, trapCode};
                mtval <= takeInterrupt ? '0 : decTval;
            end else if (isMret) begin
                mstatus[mstatusMieBit] <= mstatus[mstatusMpieBit];
            end else if (takeCsrOp && !readOnly) begin
                // Later assignments override the counter increments
                case (decNumber)
                    csrNumMstatus:   mstatus <= writeValue;
                    csrNumMie:       mie <= writeValue;
                    csrNumMtvec:     mtvecBase <= writeValue[xlen-1:mtvecBaseLsb];
                    csrNumMepc:      mepc <= writeValue;
                    csrNumMcause:    mcause <= writeValue;
                    csrNumMtval:     mtval <= writeValue;
                    csrNumMscratch:  mscratch <= writeValue;
                    csrNumMcycle:    mcycle <= writeValue;
                    csrNumMcycleh:   mcycleh <= writeValue;
                    csrNumMinstret:  minstret <= writeValue;
                    csrNumMinstreth: minstreth <= writeValue;
                    csrNumAxlevel:   axlevel <= writeValue;
                    default:         ;          // mip is read only
                endcase
            end
        end
    end

    assign mstatusMie = mstatus[mstatusMieBit];
    assign mieBits = mie;
    assign mepcValue = mepc;

endmodule

/* hdl/csrPkg.sv */
/*
 Machine-mode CSR numbers and data widths
 CSR operation encoding
 Field positions inside mstatus, mie, mip, mtvec and mcause
*/
package csrPkg;

    localparam int csrNumWidth = 12;
    localparam int xlen = 32;
    localparam int retireWidth = 2;     // Up to 3 retired per cycle

    // Standard machine-mode numbers
    localparam logic [csrNumWidth-1:0] csrNumMstatus = 12'h300;
    localparam logic [csrNumWidth-1:0] csrNumMie = 12'h304;
    localparam logic [csrNumWidth-1:0] csrNumMtvec = 12'h305;
    localparam logic [csrNumWidth-1:0] csrNumMscratch = 12'h340;
    localparam logic [csrNumWidth-1:0] csrNumMepc = 12'h341;
    localparam logic [csrNumWidth-1:0] csrNumMcause = 12'h342;
    localparam logic [csrNumWidth-1:0] csrNumMtval = 12'h343;
    localparam logic [csrNumWidth-1:0] csrNumMip = 12'h344;

    // Counters, each half on its own number
    localparam logic [csrNumWidth-1:0] csrNumMcycle = 12'hB00;
    localparam logic [csrNumWidth-1:0] csrNumMinstret = 12'hB02;
    localparam logic [csrNumWidth-1:0] csrNumMcycleh = 12'hB80;
    localparam logic [csrNumWidth-1:0] csrNumMinstreth = 12'hB82;

    localparam logic [csrNumWidth-1:0] csrNumAxlevel = 12'h7C0;   // Implementation specific

    // Same low bits as funct3 of CSRRW, CSRRS and CSRRC
    typedef enum logic [1:0] {
        csrOpWrite = 2'd1,
        csrOpSet = 2'd2,
        csrOpClear = 2'd3
    } csrOpE;

    // mstatus
    localparam int mstatusMieBit = 3;
    localparam int mstatusMpieBit = 7;

    // mie and mip share the layout
    localparam int irqTimerBit = 7;
    localparam int irqExternalBit = 11;

    // mtvec direct mode only, low bits read as zero
    localparam int mtvecBaseLsb = 2;

    // Interrupt flag of mcause
    localparam int mcauseIntBit = xlen - 1;

endpackage

/* hdl/csrRespondStage.sv */
/*
 Output stage
 Registers the CSR read result and the trap redirect target
*/
module csrRespondStage (
    input  logic                                        clk,
    input  logic                                        arstN,
    input  logic                                        takeCsrOp,
    input  logic                                        takeInterrupt,
    input  logic                                        takeException,
    input  trapPkg::causeE                              decCause,
    input  logic [csrPkg::xlen-1:0]                     readData,
    input  logic [csrPkg::xlen-1:csrPkg::mtvecBaseLsb]  mtvecBase,
    input  logic [csrPkg::xlen-1:0]                     mepcValue,
    output logic                                        rspValid,
    output logic [csrPkg::xlen-1:0]                     rspData,
    output logic                                        redirValid,
    output logic [csrPkg::xlen-1:0]                     redirTarget
);
    import csrPkg::*;
    import trapPkg::*;

    logic            isMret;
    logic            takeTrap;
    logic [xlen-1:0] trapTarget;

    assign isMret = takeException && (decCause == cauMret);
    assign takeTrap = takeInterrupt || takeException;
    // Old register values, so MRET sees mepc before any update
    assign trapTarget = isMret ? mepcValue : {mtvecBase, {mtvecBaseLsb{1'b0}}};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rspValid <= 1'b0;
            redirValid <= 1'b0;
        end else begin
            rspValid <= takeCsrOp;
            redirValid <= takeTrap;
        end
    end

    always_ff @(posedge clk) begin
        if (takeCsrOp) rspData <= readData;
        if (takeTrap) redirTarget <= trapTarget;
    end

endmodule

/* hdl/csrSubsystem.sv */
/*
 Top level of the CSR subsystem
 Decode, arbitration with register file, and response stage
*/
module csrSubsystem (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            reqValid,
    input  logic [csrPkg::csrNumWidth-1:0]  reqNumber,
    input  csrPkg::csrOpE                   reqOp,
    input  logic [csrPkg::xlen-1:0]         reqWriteData,
    input  logic [csrPkg::xlen-1:0]         reqPc,
    input  logic                            excValid,
    input  trapPkg::causeE                  excCause,
    input  logic [csrPkg::xlen-1:0]         excPc,
    input  logic [csrPkg::xlen-1:0]         excTval,
    input  logic [csrPkg::retireWidth-1:0]  retireCount,
    input  logic                            irqTimer,
    input  logic                            irqExternal,
    output logic                            rspValid,
    output logic [csrPkg::xlen-1:0]         rspData,
    output logic                            redirValid,
    output logic [csrPkg::xlen-1:0]         redirTarget
);

    logic                                        decValid;
    logic                                        decIsExc;
    trapPkg::causeE                              decCause;
    logic [csrPkg::csrNumWidth-1:0]              decNumber;
    csrPkg::csrOpE                               decOp;
    logic [csrPkg::xlen-1:0]                     decData;
    logic [csrPkg::xlen-1:0]                     decPc;
    logic [csrPkg::xlen-1:0]                     decTval;

    logic                                        takeInterrupt;
    logic                                        takeException;
    logic                                        takeCsrOp;
    logic [trapPkg::causeWidth-1:0]              trapCode;
    logic                                        trapIsInterrupt;

    logic [csrPkg::xlen-1:0]                     readData;
    logic                                        mstatusMie;
    logic [csrPkg::xlen-1:0]                     mieBits;
    logic [csrPkg::xlen-1:0]                     mipBits;
    logic [csrPkg::xlen-1:csrPkg::mtvecBaseLsb]  mtvecBase;
    logic [csrPkg::xlen-1:0]                     mepcValue;

    csrDecodeStage decodeStage (.*);

    trapArbiter arbiter (.*);

    csrFile regFile (.*);

    csrRespondStage respondStage (.*);

endmodule

/* hdl/trapArbiter.sv */
/*
 Priority arbiter beside the execute stage
 Interrupt, then exception, then CSR operation
 Forms the mcause code and interrupt flag
*/
module trapArbiter (
    input  logic                            decValid,
    input  logic                            decIsExc,
    input  trapPkg::causeE                  decCause,
    input  logic                            mstatusMie,
    input  logic [csrPkg::xlen-1:0]         mieBits,
    input  logic [csrPkg::xlen-1:0]         mipBits,
    output logic                            takeInterrupt,
    output logic                            takeException,
    output logic                            takeCsrOp,
    output logic [trapPkg::causeWidth-1:0]  trapCode,
    output logic                            trapIsInterrupt
);
    import csrPkg::*;
    import trapPkg::*;

    logic [xlen-1:0]       pending;
    logic                  intFound;
    logic [causeWidth-1:0] intCode;

    assign pending = mieBits & mipBits;

    // Walk from lowest priority so the first entry ends up on top
    always_comb begin
        intFound = 1'b0;
        intCode = '0;
        for (int i = intCount - 1; i >= 0; i--) begin
            if (pending[intPrioCode[i]]) begin
                intFound = 1'b1;
                intCode = intPrioCode[i];
            end
        end
    end

    // An interrupt discards whatever is in flight
    assign takeInterrupt = mstatusMie && intFound;
    assign takeException = !takeInterrupt && decValid && decIsExc;
    assign takeCsrOp = !takeInterrupt && decValid && !decIsExc;

    assign trapCode = takeInterrupt ? intCode : decCause;
    assign trapIsInterrupt = takeInterrupt;

endmodule

/* hdl/trapPkg.sv */
/*
 Exception cause codes, including the internal MRET code
 Interrupt codes and their priority order
*/
package trapPkg;

    localparam int causeWidth = 4;

    typedef enum logic [causeWidth-1:0] {
        cauInsnMisaligned = 4'd0,
        cauIllegalInsn = 4'd2,
        cauBreakpoint = 4'd3,
        cauLoadMisaligned = 4'd4,
        cauStoreMisaligned = 4'd6,
        cauEcall = 4'd11,
        cauMret = 4'd15         // Internal only, never reaches mcause
    } causeE;

    // Interrupt codes equal the bit positions in mie and mip
    localparam logic [causeWidth-1:0] intCodeTimer = 4'd7;
    localparam logic [causeWidth-1:0] intCodeExternal = 4'd11;

    localparam int intCount = 2;

    // Entry 0 has the highest priority
    localparam logic [intCount-1:0][causeWidth-1:0] intPrioCode = {
        intCodeTimer,
        intCodeExternal
    };

endpackage

/* tb.f */
+incdir+verification
hdl/csrPkg.sv
hdl/trapPkg.sv
hdl/csrDecodeStage.sv
hdl/trapArbiter.sv
hdl/csrFile.sv
hdl/csrRespondStage.sv
hdl/csrSubsystem.sv
verification/tbCsrSubsystem.sv

/* verification/csrModel.svh */
/*
 Reference model of the CSR subsystem
 Decode register, CSR state, counters, trap rules and expected outputs
*/
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

logic        mDecValid, mDecIsExc;
logic [3:0]  mDecCause;
logic [11:0] mDecNum;
logic [1:0]  mDecOp;
logic [31:0] mDecData, mDecPc, mDecTval;
logic [31:0] mStatus, mIe, mTvec, mEpc, mCause, mTval, mScratch, mAxlevel;
logic [31:0] mCycleLo, mCycleHi, mInstretLo, mInstretHi;
logic        mipT, mipE;
logic [1:0]  mRetire;                  // retireCount seen one cycle ago
logic        expRspValid, expRedirValid;
logic [31:0] expRspData, expRedirTarget;

task automatic resetModel();
    {mDecValid, mDecIsExc, mDecCause, mDecNum, mDecOp} = '0;
    {mDecData, mDecPc, mDecTval} = '0;
    {mStatus, mIe, mTvec, mEpc, mCause, mTval, mScratch, mAxlevel} = '0;
    {mCycleLo, mCycleHi, mInstretLo, mInstretHi} = '0;
    {mipT, mipE, mRetire, expRspValid, expRedirValid} = '0;
    {expRspData, expRedirTarget} = '0;
endtask

function automatic logic [31:0] mipValue();
    return (32'(mipE) << 11) | (32'(mipT) << 7);
endfunction

function automatic logic isKnownCsr(input logic [11:0] num);
    return num inside {csrNumMstatus, csrNumMie, csrNumMip, csrNumMtvec, csrNumMepc,
                       csrNumMcause, csrNumMtval, csrNumMscratch, csrNumMcycle,
                       csrNumMcycleh, csrNumMinstret, csrNumMinstreth, csrNumAxlevel};
endfunction

function automatic logic [31:0] lookupCsr(input logic [11:0] num);
    case (num)
        csrNumMstatus:   return mStatus;
        csrNumMie:       return mIe;
        csrNumMip:       return mipValue();
        csrNumMtvec:     return mTvec;
        csrNumMepc:      return mEpc;
        csrNumMcause:    return mCause;
        csrNumMtval:     return mTval;
        csrNumMscratch:  return mScratch;
        csrNumMcycle:    return mCycleLo;
        csrNumMcycleh:   return mCycleHi;
        csrNumMinstret:  return mInstretLo;
        csrNumMinstreth: return mInstretHi;
        csrNumAxlevel:   return mAxlevel;
        default:         return 32'd0;
    endcase
endfunction

// One clock edge with the inputs of the cycle it ends
task automatic stepModel(input logic rv, input logic [11:0] num, input logic [1:0] op,
                         input logic [31:0] data, input logic [31:0] pc, input logic ev,
                         input logic [3:0] cause, input logic [31:0] tval,
                         input logic [1:0] retire, input logic irqT, input logic irqE);
    logic [31:0] pend, rd, wv;
    logic [32:0] sum;
    logic        intr, exc, csrOp, isMret, illegal;
    logic [3:0]  code;
    pend = mipValue() & mIe;
    intr = mStatus[3] && (pend[11] || pend[7]);
    code = pend[11] ? 4'd11 : 4'd7;       // External first
    exc = !intr && mDecValid && mDecIsExc;
    csrOp = !intr && mDecValid && !mDecIsExc;
    isMret = exc && (mDecCause == 4'd15);
    rd = lookupCsr(mDecNum);
    case (mDecOp)
        2'd2:    wv = rd | mDecData;
        2'd3:    wv = rd & ~mDecData;
        default: wv = mDecData;
    endcase
    expRspValid = csrOp;
    if (csrOp) expRspData = rd;
    expRedirValid = intr || exc;
    if (intr || exc) expRedirTarget = isMret ? mEpc : mTvec;
    sum = {1'b0, mCycleLo} + 33'd1;
    mCycleLo = sum[31:0];
    mCycleHi = mCycleHi + 32'(sum[32]);
    sum = {1'b0, mInstretLo} + 33'(mRetire);
    mInstretLo = sum[31:0];
    mInstretHi = mInstretHi + 32'(sum[32]);
    mRetire = retire;
    mipT = irqT;
    mipE = irqE;
    if (intr || (exc && !isMret)) begin
        mStatus[7] = mStatus[3];
        mStatus[3] = 1'b0;
        mEpc = mDecPc;
        mCause = {intr, 27'd0, intr ? code : mDecCause};
        mTval = intr ? 32'd0 : mDecTval;
    end else if (isMret) begin
        mStatus[3] = mStatus[7];
    end else if (csrOp && !(mDecOp == 2'd3 && mDecData == 32'd0)) begin   // Clear of zero only reads
        case (mDecNum)
            csrNumMstatus:   mStatus = wv;
            csrNumMie:       mIe = wv;
            csrNumMtvec:     mTvec = wv & 32'hFFFF_FFFC;
            csrNumMepc:      mEpc = wv;
            csrNumMcause:    mCause = wv;
            csrNumMtval:     mTval = wv;
            csrNumMscratch:  mScratch = wv;
            csrNumMcycle:    mCycleLo = wv;
            csrNumMcycleh:   mCycleHi = wv;
            csrNumMinstret:  mInstretLo = wv;
            csrNumMinstreth: mInstretHi = wv;
            csrNumAxlevel:   mAxlevel = wv;
            default:         ;
        endcase
    end
    illegal = !isKnownCsr(num) || (num == csrNumMip && !(op == 2'd3 && data == 32'd0));
    mDecValid = rv || ev;
    mDecIsExc = ev || (rv && illegal);
    mDecCause = ev ? cause : 4'd2;
    mDecNum = num;
    mDecOp = op;
    mDecData = data;
    mDecPc = pc;
    mDecTval = ev ? tval : {20'd0, num};
endtask

`endif

/* verification/tbCsrSubsystem.sv */
/*
 Testbench for the CSR subsystem
 Random CSR traffic, traps and interrupts checked against a model
*/
module tbCsrSubsystem;
    import csrPkg::*;
    import trapPkg::*;

    localparam int rwIters = 40;
    localparam int illIters = 10;
    localparam int excIters = 5;
    localparam int retireCycles = 50;
    localparam int cycleLimit = 10 + rwIters * 4 + illIters * 9 + excIters * 18 + 1
                                + 29 + retireCycles + 6 + 20 + 200;
    localparam logic [11:0] rwNumbers [8] = '{csrNumMstatus, csrNumMie, csrNumMtvec,
        csrNumMepc, csrNumMcause, csrNumMtval, csrNumMscratch, csrNumAxlevel};

    logic clk, arstN, reqValid, excValid, irqTimer, irqExternal;
    logic rspValid, redirValid;
    logic [11:0] reqNumber;
    csrOpE reqOp;
    causeE excCause;
    logic [31:0] reqWriteData, reqPc, excPc, excTval, rspData, redirTarget;
    logic [1:0] retireCount;

    logic curIrqT, curIrqE;
    logic [1:0] curRetire;
    logic [31:0] lastRsp, firstRead;
    string testName;
    int errCount, checkCount, testErrStart, cycleCount;

    `include "csrModel.svh"

    csrSubsystem UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    initial begin
        cycleCount = 0;
        while (cycleCount <= cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("Some tests failed");
        $finish;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %h, actual %h", testName, name, expected, actual);
            errCount++;
        end
    endtask

    // Drive one cycle, check the outputs, then advance the model
    task automatic runCycle(input logic rv, input logic [11:0] num, input logic [1:0] op,
                            input logic [31:0] data, input logic ev, input logic [3:0] cause,
                            input logic [31:0] tval);
        logic [31:0] pc;
        logic [31:0] trapPc;
        pc = $urandom & 32'hFFFF_FFFC;
        trapPc = $urandom & 32'hFFFF_FFFC;
        @(posedge clk);
        reqValid <= rv;
        reqNumber <= num;
        reqOp <= csrOpE'(op);
        reqWriteData <= data;
        reqPc <= pc;
        excValid <= ev;
        excCause <= causeE'(cause);
        excPc <= trapPc;
        excTval <= tval;
        retireCount <= curRetire;
        irqTimer <= curIrqT;
        irqExternal <= curIrqE;
        @(negedge clk);
        checkValue("rspValid", 32'(expRspValid), 32'(rspValid));
        checkValue("redirValid", 32'(expRedirValid), 32'(redirValid));
        if (expRspValid && rspValid) checkValue("rspData", expRspData, rspData);
        if (expRedirValid && redirValid) checkValue("redirTarget", expRedirTarget, redirTarget);
        if (rspValid) lastRsp = rspData;
        stepModel(rv, num, op, data, ev ? trapPc : pc, ev, cause, tval, curRetire,
                  curIrqT, curIrqE);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) runCycle(1'b0, 12'd0, 2'd0, 32'd0, 1'b0, 4'd0, 32'd0);
    endtask

    task automatic writeCsr(input logic [11:0] num, input logic [31:0] data);
        runCycle(1'b1, num, 2'd1, data, 1'b0, 4'd0, 32'd0);
    endtask

    // Clear of zero reads the CSR into lastRsp
    task automatic readCsr(input logic [11:0] num);
        runCycle(1'b1, num, 2'd3, 32'd0, 1'b0, 4'd0, 32'd0);
        idleCycles(2);
    endtask

    task automatic raiseException(input logic [3:0] cause, input logic [31:0] tval);
        runCycle(1'b0, 12'd0, 2'd0, 32'd0, 1'b1, cause, tval);
        idleCycles(2);
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrStart = errCount;
    endtask

    task automatic finishTest();
        $display("Test %s: %s, %0d errors", testName,
                 (errCount == testErrStart) ? "ok" : "mismatch", errCount - testErrStart);
    endtask

    initial begin
        logic [11:0] num;
        logic [3:0] cause;
        logic [31:0] data;
        {reqValid, excValid, irqTimer, irqExternal, curIrqT, curIrqE} = '0;
        {reqNumber, reqWriteData, reqPc, excPc, excTval, lastRsp, firstRead} = '0;
        reqOp = csrOpWrite;
        excCause = cauInsnMisaligned;
        {retireCount, curRetire} = '0;
        {errCount, checkCount} = '0;
        testName = "reset";
        void'($urandom(32'h4f21_e3df));
        resetModel();
        arstN = 1'b0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
        stepModel(1'b0, 12'd0, 2'd0, 32'd0, 32'd0, 1'b0, 4'd0, 32'd0, 2'd0, 1'b0, 1'b0);

        startTest("readWrite");
        repeat (rwIters) begin
            num = rwNumbers[$urandom_range(0, 7)];
            runCycle(1'b1, num, 2'($urandom_range(1, 3)), $urandom, 1'b0, 4'd0, 32'd0);
            readCsr(num);
            if (num == csrNumMtvec) checkValue("mtvec low bits", 32'd0, {30'd0, lastRsp[1:0]});
        end
        finishTest();

        startTest("illegal");
        for (int i = 0; i < illIters; i++) begin
            num = (i % 2 == 0) ? (12'hC00 | 12'($urandom_range(0, 255))) : csrNumMip;
            runCycle(1'b1, num, 2'($urandom_range(1, 2)), $urandom | 32'd1, 1'b0, 4'd0, 32'd0);
            idleCycles(2);
            readCsr(csrNumMcause);
            checkValue("mcause", 32'd2, lastRsp);
            readCsr(csrNumMtval);
            checkValue("mtval", {20'd0, num}, lastRsp);
        end
        finishTest();

        startTest("exceptionMret");
        writeCsr(csrNumMstatus, 32'h8);
        repeat (excIters) begin
            cause = 4'($urandom_range(0, 4));
            cause = (cause == 4'd0) ? 4'd0 : (cause == 4'd1) ? 4'd3 : (cause == 4'd2) ? 4'd4
                  : (cause == 4'd3) ? 4'd6 : 4'd11;
            data = $urandom;
            raiseException(cause, data);
            readCsr(csrNumMtval);
            checkValue("mtval", data, lastRsp);
            readCsr(csrNumMstatus);
            checkValue("MIE after trap", 32'd0, 32'(lastRsp[3]));
            checkValue("MPIE after trap", 32'd1, 32'(lastRsp[7]));
            readCsr(csrNumMepc);
            raiseException(4'd15, 32'd0);       // MRET
            readCsr(csrNumMstatus);
            checkValue("MIE after mret", 32'd1, 32'(lastRsp[3]));
        end
        finishTest();

        startTest("interrupt");
        writeCsr(csrNumMie, 32'h0000_0880);
        writeCsr(csrNumMstatus, 32'h8);
        curIrqT = 1'b1;
        curIrqE = 1'b1;
        idleCycles(4);
        curIrqE = 1'b0;
        readCsr(csrNumMcause);
        checkValue("mcause external", 32'h8000_000B, lastRsp);
        readCsr(csrNumMip);                     // MIE now clear so the timer stays pending
        checkValue("mip timer", 32'h0000_0080, lastRsp);
        writeCsr(csrNumMstatus, 32'h8);
        idleCycles(3);
        curIrqT = 1'b0;
        readCsr(csrNumMcause);
        checkValue("mcause timer", 32'h8000_0007, lastRsp);
        writeCsr(csrNumMie, 32'd0);             // Pending only, never taken
        writeCsr(csrNumMstatus, 32'h8);
        curIrqE = 1'b1;
        idleCycles(3);
        readCsr(csrNumMip);
        checkValue("mip external", 32'h0000_0800, lastRsp);
        curIrqE = 1'b0;
        idleCycles(2);
        finishTest();

        startTest("minstret");
        repeat (retireCycles) begin
            curRetire = 2'($urandom_range(0, 3));
            idleCycles(1);
        end
        curRetire = 2'd0;
        readCsr(csrNumMinstret);
        readCsr(csrNumMinstreth);
        finishTest();

        startTest("counters");
        writeCsr(csrNumMcycleh, 32'd0);
        writeCsr(csrNumMcycle, 32'hFFFF_FFFF);
        idleCycles(2);
        readCsr(csrNumMcycleh);
        checkValue("mcycleh carry", 32'd1, lastRsp);
        readCsr(csrNumMcycle);
        firstRead = lastRsp;
        idleCycles(7);
        readCsr(csrNumMcycle);
        // Reads exactly 10 cycles apart
        checkValue("mcycle delta", 32'd10, lastRsp - firstRead);
        finishTest();

        $display("Checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
